// File: src/mfcc_pkg.sv
`default_nettype none

package mfcc_pkg;

  // frame and coefficient counts
  localparam int NUM_FILTERS = 10;
  localparam int N_DCT       = 6;

  // log energies unsigned, cepstral outputs signed
  localparam int DATA_W = 16;

  // cosine entries in Q1.14
  localparam int COEF_W    = 16;
  localparam int COEF_FRAC = 14;

  // table layout, entry k*NUM_FILTERS+n
  localparam int TABLE_DEPTH = 64;
  localparam int TABLE_USED  = N_DCT * NUM_FILTERS;
  localparam int ADDR_W      = 6;

  localparam int ACC_W = 36;

  // counter widths inside the engine
  localparam int K_W = $clog2(N_DCT);
  localparam int N_W = $clog2(NUM_FILTERS);

  // host bus
  localparam int APB_ADDR_W = 8;
  localparam int APB_DATA_W = 32;

  // one frame of log mel energies
  typedef logic [NUM_FILTERS-1:0][DATA_W-1:0] log_frame_t;

  // single access to the coefficient memory
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [COEF_W-1:0] wdata;
    logic              we;
  } coef_req_t;

  // one cepstral coefficient on the output stream
  typedef struct packed {
    logic signed [DATA_W-1:0] data;
    logic                     last;
  } dct_beat_t;

  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    ACCUM = 2'd1,
    EMIT  = 2'd2
  } dct_state_e;

endpackage

`default_nettype wire

// File: src/coef_table.sv
`timescale 1ns/1ps
`default_nettype none

module coef_table (
  input  logic                         clk_in,
  input  mfcc_pkg::coef_req_t          req,
  input  logic                         en,
  output logic [mfcc_pkg::COEF_W-1:0]  rdata
);

  import mfcc_pkg::*;

  logic [COEF_W-1:0] mem [TABLE_DEPTH];

  // read-first on a simultaneous write to the same word
  always_ff @(posedge clk_in) begin
    if (en) begin
      if (req.we) begin
        mem[req.addr] <= req.wdata;
      end
      rdata <= mem[req.addr];
    end
  end

endmodule

`default_nettype wire

// File: src/coef_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module coef_arbiter (
  input  logic                 clk_in,
  input  logic                 rst_in,

  input  mfcc_pkg::coef_req_t  eng_req,
  input  logic                 eng_valid,
  output logic                 eng_gnt,
  output logic                 eng_rvalid,

  input  mfcc_pkg::coef_req_t  host_req,
  input  logic                 host_valid,
  output logic                 host_gnt,
  output logic                 host_rvalid,

  output mfcc_pkg::coef_req_t  mem_req,
  output logic                 mem_en
);

  import mfcc_pkg::*;

  logic eng_rd_q;
  logic host_rd_q;

  // engine always wins
  assign eng_gnt  = eng_valid;
  assign host_gnt = host_valid & ~eng_valid;

  assign mem_req = eng_valid ? eng_req : host_req;
  assign mem_en  = eng_valid | host_valid;

  // remember which read goes out, data returns next cycle
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      eng_rd_q  <= 1'b0;
      host_rd_q <= 1'b0;
    end else begin
      eng_rd_q  <= eng_gnt & ~eng_req.we;
      host_rd_q <= host_gnt & ~host_req.we;
    end
  end

  assign eng_rvalid  = eng_rd_q;
  assign host_rvalid = host_rd_q;

endmodule

`default_nettype wire

// File: src/apb_coef_port.sv
`timescale 1ns/1ps
`default_nettype none

module apb_coef_port (
  input  logic                             clk_in,
  input  logic                             rst_in,

  input  logic [mfcc_pkg::APB_ADDR_W-1:0]  paddr,
  input  logic                             psel,
  input  logic                             penable,
  input  logic                             pwrite,
  input  logic [mfcc_pkg::APB_DATA_W-1:0]  pwdata,
  output logic [mfcc_pkg::APB_DATA_W-1:0]  prdata,
  output logic                             pready,
  output logic                             pslverr,

  output mfcc_pkg::coef_req_t              req,
  output logic                             req_valid,
  input  logic                             gnt,
  input  logic                             rvalid,
  input  logic [mfcc_pkg::COEF_W-1:0]      rdata
);

  import mfcc_pkg::*;

  logic [ADDR_W-1:0] word_idx;
  logic              access;
  logic              in_range;
  logic              busy;

  // byte address, word aligned
  assign word_idx = paddr[ADDR_W+1:2];
  assign access   = psel & penable;
  assign in_range = (word_idx < TABLE_USED);

  assign req.addr  = word_idx;
  assign req.wdata = pwdata[COEF_W-1:0];
  assign req.we    = pwrite;

  // one memory access per transfer
  assign req_valid = access & in_range & ~busy;

  // read granted, waiting for the table word
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      busy <= 1'b0;
    end else if (rvalid) begin
      busy <= 1'b0;
    end else if (req_valid && gnt && !pwrite) begin
      busy <= 1'b1;
    end
  end

  // bad index finishes at once and never touches the table
  assign pslverr = access & ~in_range;
  assign pready  = access & (~in_range | (pwrite & gnt) | (~pwrite & rvalid));

  assign prdata = rvalid ? {{(APB_DATA_W-COEF_W){rdata[COEF_W-1]}}, rdata} : '0;

endmodule

`default_nettype wire

// File: src/dct_engine.sv
`timescale 1ns/1ps
`default_nettype none

module dct_engine (
  input  logic                         clk_in,
  input  logic                         rst_in,

  input  mfcc_pkg::log_frame_t         log_frame,
  input  logic                         log_valid,
  output logic                         log_ready,

  output mfcc_pkg::coef_req_t          req,
  output logic                         req_valid,
  input  logic                         gnt,
  input  logic                         rvalid,
  input  logic [mfcc_pkg::COEF_W-1:0]  rdata,

  output mfcc_pkg::dct_beat_t          dct_beat,
  output logic                         dct_valid,
  input  logic                         dct_ready
);

  import mfcc_pkg::*;

  dct_state_e state;

  logic [K_W-1:0]    k_idx;
  logic [ADDR_W-1:0] addr_base;
  logic [N_W-1:0]    n_issue;
  logic [N_W-1:0]    n_q;
  logic              last_q;
  logic              issue_done;
  logic              frame_acc;
  logic              beat_acc;

  log_frame_t               frame_q;
  logic signed [ACC_W-1:0]  acc;
  logic signed [DATA_W:0]   energy_s;
  logic signed [COEF_W+DATA_W:0] prod;
  logic signed [ACC_W-1:0]  acc_shift;
  logic                     fits;

  assign log_ready = (state == IDLE);
  assign frame_acc = log_valid & log_ready;
  assign dct_valid = (state == EMIT);
  assign beat_acc  = dct_valid & dct_ready;

  // reads for coefficient k, n = 0 .. NUM_FILTERS-1
  assign issue_done = (n_issue == NUM_FILTERS);
  assign req_valid  = (state == ACCUM) & ~issue_done;
  assign req.addr   = addr_base + ADDR_W'(n_issue);
  assign req.wdata  = '0;
  assign req.we     = 1'b0;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state     <= IDLE;
      k_idx     <= '0;
      addr_base <= '0;
      n_issue   <= '0;
      last_q    <= 1'b0;
    end else begin
      if (req_valid && gnt) begin
        n_issue <= n_issue + 1'b1;
        last_q  <= (n_issue == NUM_FILTERS-1);
      end
      case (state)
        IDLE: begin
          if (frame_acc) begin
            state     <= ACCUM;
            k_idx     <= '0;
            addr_base <= '0;
            n_issue   <= '0;
          end
        end
        ACCUM: begin
          // last term lands in acc this cycle
          if (rvalid && last_q) begin
            state <= EMIT;
          end
        end
        EMIT: begin
          if (dct_ready) begin
            n_issue <= '0;
            if (k_idx == N_DCT-1) begin
              state <= IDLE;
            end else begin
              state     <= ACCUM;
              k_idx     <= k_idx + 1'b1;
              addr_base <= addr_base + ADDR_W'(NUM_FILTERS);
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // filter index follows its read through the table latency
  assign energy_s = {1'b0, frame_q[n_q]};
  assign prod     = $signed(rdata) * energy_s;

  always_ff @(posedge clk_in) begin
    if (frame_acc) begin
      frame_q <= log_frame;
    end
    if (req_valid && gnt) begin
      n_q <= n_issue;
    end
    if (frame_acc || beat_acc) begin
      acc <= '0;
    end else if (rvalid) begin
      acc <= acc + ACC_W'(prod);
    end
  end

  // drop the Q14 scaling, clamp to 16 bit signed
  assign acc_shift = acc >>> COEF_FRAC;
  assign fits = (acc_shift[ACC_W-1:DATA_W-1] == '0) ||
                (acc_shift[ACC_W-1:DATA_W-1] == '1);

  always_comb begin
    if (fits) begin
      dct_beat.data = acc_shift[DATA_W-1:0];
    end else if (acc_shift[ACC_W-1]) begin
      dct_beat.data = {1'b1, {(DATA_W-1){1'b0}}};
    end else begin
      dct_beat.data = {1'b0, {(DATA_W-1){1'b1}}};
    end
    dct_beat.last = (k_idx == N_DCT-1);
  end

endmodule

`default_nettype wire

// File: src/mfcc_dct_top.sv
`timescale 1ns/1ps
`default_nettype none

module mfcc_dct_top (
  input  logic                             clk_in,
  input  logic                             rst_in,

  input  mfcc_pkg::log_frame_t             log_frame,
  input  logic                             log_valid,
  output logic                             log_ready,

  output mfcc_pkg::dct_beat_t              dct_beat,
  output logic                             dct_valid,
  input  logic                             dct_ready,

  input  logic [mfcc_pkg::APB_ADDR_W-1:0]  paddr,
  input  logic                             psel,
  input  logic                             penable,
  input  logic                             pwrite,
  input  logic [mfcc_pkg::APB_DATA_W-1:0]  pwdata,
  output logic [mfcc_pkg::APB_DATA_W-1:0]  prdata,
  output logic                             pready,
  output logic                             pslverr
);

  import mfcc_pkg::*;

  coef_req_t         eng_req;
  logic              eng_valid;
  logic              eng_gnt;
  logic              eng_rvalid;

  coef_req_t         host_req;
  logic              host_valid;
  logic              host_gnt;
  logic              host_rvalid;

  coef_req_t         mem_req;
  logic              mem_en;
  logic [COEF_W-1:0] mem_rdata;

  dct_engine i_engine (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .log_frame (log_frame),
    .log_valid (log_valid),
    .log_ready (log_ready),
    .req       (eng_req),
    .req_valid (eng_valid),
    .gnt       (eng_gnt),
    .rvalid    (eng_rvalid),
    .rdata     (mem_rdata),
    .dct_beat  (dct_beat),
    .dct_valid (dct_valid),
    .dct_ready (dct_ready)
  );

  apb_coef_port i_apb (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .paddr     (paddr),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .req       (host_req),
    .req_valid (host_valid),
    .gnt       (host_gnt),
    .rvalid    (host_rvalid),
    .rdata     (mem_rdata)
  );

  coef_arbiter i_arb (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .eng_req     (eng_req),
    .eng_valid   (eng_valid),
    .eng_gnt     (eng_gnt),
    .eng_rvalid  (eng_rvalid),
    .host_req    (host_req),
    .host_valid  (host_valid),
    .host_gnt    (host_gnt),
    .host_rvalid (host_rvalid),
    .mem_req     (mem_req),
    .mem_en      (mem_en)
  );

  coef_table i_table (
    .clk_in (clk_in),
    .req    (mem_req),
    .en     (mem_en),
    .rdata  (mem_rdata)
  );

endmodule

`default_nettype wire

// File: dv/tb_mfcc_dct.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mfcc_dct;

  import mfcc_pkg::*;

  localparam int APB_BOUND       = 20;
  localparam int FRAME_BOUND     = 400;
  localparam int N_APB_OPS       = 260;
  localparam int N_FRAMES        = 10;
  localparam int WATCHDOG_CYCLES = N_APB_OPS * APB_BOUND + N_FRAMES * FRAME_BOUND + 500;

  logic                  clk_in = 1'b0;
  logic                  rst_in;
  log_frame_t            log_frame;
  logic                  log_valid;
  logic                  log_ready;
  dct_beat_t             dct_beat;
  logic                  dct_valid;
  logic                  dct_ready;
  logic [APB_ADDR_W-1:0] paddr;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [APB_DATA_W-1:0] pwdata;
  logic [APB_DATA_W-1:0] prdata;
  logic                  pready;
  logic                  pslverr;

  integer seed          = 32'hd851;
  int     errors        = 0;
  int     beats_seen    = 0;
  int     beat_in_frame = 0;
  int     frames_sent   = 0;
  logic   bp_mode       = 1'b0;
  logic   frame_busy    = 1'b0;

  // host view of the cosine table
  logic [COEF_W-1:0]        tbl [TABLE_DEPTH];
  logic [DATA_W-1:0]        energy [NUM_FILTERS];
  logic signed [DATA_W-1:0] exp_q [$];

  mfcc_dct_top i_dut (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .log_frame (log_frame),
    .log_valid (log_valid),
    .log_ready (log_ready),
    .dct_beat  (dct_beat),
    .dct_valid (dct_valid),
    .dct_ready (dct_ready),
    .paddr     (paddr),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr)
  );

  always #20 clk_in = ~clk_in;

  task automatic value_error(input string msg);
    errors++;
    $display("[ERROR] %0t: %s", $time, msg);
  endtask

  task automatic protocol_error(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  // one APB transfer with access cycles counted up to pready
  task automatic apb_xfer(input logic wr, input int idx, input logic [APB_DATA_W-1:0] wdata,
                          output logic [APB_DATA_W-1:0] rdata, output logic err,
                          output int cycles);
    @(posedge clk_in);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= APB_ADDR_W'(idx << 2);
    pwdata  <= wdata;
    @(posedge clk_in);
    penable <= 1'b1;
    cycles = 0;
    do begin
      @(posedge clk_in);
      cycles++;
    end while (!pready && cycles < APB_BOUND);
    rdata = prdata;
    err   = pslverr;
    if (!pready) begin
      protocol_error($sformatf("APB transfer to word %0d never completed", idx));
    end
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic write_entry(input int idx, input logic [APB_DATA_W-1:0] wdata,
                             input int exp_cycles);
    logic [APB_DATA_W-1:0] rd;
    logic                  err;
    int                    cyc;
    apb_xfer(1'b1, idx, wdata, rd, err, cyc);
    tbl[idx] = wdata[COEF_W-1:0];
    assert (!err) else value_error($sformatf("write to word %0d got pslverr", idx));
    assert (exp_cycles == 0 || cyc == exp_cycles)
      else value_error($sformatf("write to word %0d took %0d cycles", idx, cyc));
  endtask

  task automatic check_entry(input int idx, input int exp_cycles);
    logic [APB_DATA_W-1:0] rd;
    logic [APB_DATA_W-1:0] expected;
    logic                  err;
    int                    cyc;
    expected = APB_DATA_W'($signed(tbl[idx]));
    apb_xfer(1'b0, idx, '0, rd, err, cyc);
    assert (rd === expected && !err)
      else value_error($sformatf("read word %0d: got %h err %0b, expected %h",
                                 idx, rd, err, expected));
    assert (exp_cycles == 0 || cyc == exp_cycles)
      else value_error($sformatf("read of word %0d took %0d cycles", idx, cyc));
  endtask

  task automatic check_bad_index(input int idx);
    logic [APB_DATA_W-1:0] rd;
    logic                  err;
    int                    cyc;
    apb_xfer(1'b1, idx, 32'h0000_1234, rd, err, cyc);
    assert (err && cyc == 1)
      else value_error($sformatf("write to word %0d: err %0b after %0d cycles", idx, err, cyc));
    apb_xfer(1'b0, idx, '0, rd, err, cyc);
    assert (err && cyc == 1 && rd === '0)
      else value_error($sformatf("read of word %0d: data %h err %0b after %0d cycles",
                                 idx, rd, err, cyc));
  endtask

  // sum of cosine times energy with Q14 dropped and clamped to 16 bit signed
  function automatic logic signed [DATA_W-1:0] model_coef(input int k);
    longint sum;
    longint scaled;
    longint max_v;
    max_v = (longint'(1) <<< (DATA_W - 1)) - 1;
    sum = 0;
    for (int n = 0; n < NUM_FILTERS; n++) begin
      sum += longint'($signed(tbl[k * NUM_FILTERS + n])) * longint'(energy[n]);
    end
    scaled = sum >>> COEF_FRAC;
    if (scaled > max_v) begin
      scaled = max_v;
    end else if (scaled < -max_v - 1) begin
      scaled = -max_v - 1;
    end
    return DATA_W'(scaled);
  endfunction

  task automatic fill_energy(input logic random_fill, input logic [DATA_W-1:0] value);
    for (int n = 0; n < NUM_FILTERS; n++) begin
      energy[n] = random_fill ? DATA_W'($random(seed)) : value;
    end
  endtask

  task automatic send_frame();
    log_frame_t frame;
    int         target;
    int         cyc;
    for (int k = 0; k < N_DCT; k++) begin
      exp_q.push_back(model_coef(k));
    end
    for (int n = 0; n < NUM_FILTERS; n++) begin
      frame[n] = energy[n];
    end
    frames_sent++;
    target = frames_sent * N_DCT;
    @(posedge clk_in);
    log_frame <= frame;
    log_valid <= 1'b1;
    cyc = 0;
    do begin
      @(posedge clk_in);
      cyc++;
    end while (!log_ready && cyc < FRAME_BOUND);
    log_valid <= 1'b0;
    if (!log_ready) begin
      protocol_error("frame was never accepted, log_ready stayed low");
    end
    cyc = 0;
    while (beats_seen < target && cyc < FRAME_BOUND) begin
      @(negedge clk_in);
      cyc++;
    end
    if (beats_seen < target) begin
      protocol_error($sformatf("frame stopped after %0d of %0d coefficients",
                               beats_seen - target + N_DCT, N_DCT));
    end
  endtask

  always @(posedge clk_in) begin
    if (bp_mode) begin
      dct_ready <= (($random(seed) & 3) != 0);
    end else begin
      dct_ready <= 1'b1;
    end
  end

  // output beat scoreboard
  always @(posedge clk_in) begin
    logic signed [DATA_W-1:0] expected;
    if (!rst_in && dct_valid && dct_ready) begin
      if (exp_q.size() == 0) begin
        protocol_error("a coefficient came out with no frame outstanding");
      end else begin
        expected = exp_q.pop_front();
        assert (dct_beat.data === expected)
          else value_error($sformatf("coefficient %0d: got %0d, expected %0d",
                                     beat_in_frame, dct_beat.data, expected));
        assert (dct_beat.last === (beat_in_frame == N_DCT - 1))
          else value_error($sformatf("coefficient %0d: last flag %0b",
                                     beat_in_frame, dct_beat.last));
      end
      beat_in_frame = (beat_in_frame == N_DCT - 1) ? 0 : beat_in_frame + 1;
      beats_seen++;
    end
  end

  always @(posedge clk_in) begin
    if (rst_in) begin
      frame_busy <= 1'b0;
    end else if (log_valid && log_ready) begin
      frame_busy <= 1'b1;
    end else if (dct_valid && dct_ready && dct_beat.last) begin
      frame_busy <= 1'b0;
    end
  end

  a_beat_hold: assert property (@(posedge clk_in) disable iff (rst_in)
    dct_valid && !dct_ready |=> dct_valid && $stable(dct_beat))
    else protocol_error("output beat changed before it was accepted");

  a_frame_busy: assert property (@(posedge clk_in) disable iff (rst_in)
    frame_busy |-> !log_ready)
    else protocol_error("log_ready rose before the last coefficient was accepted");

  a_bad_index: assert property (@(posedge clk_in) disable iff (rst_in)
    psel && penable && paddr[7:2] >= TABLE_USED |-> pready && pslverr)
    else protocol_error("out-of-range APB access did not end with pslverr in its first cycle");

  a_good_index: assert property (@(posedge clk_in) disable iff (rst_in)
    psel && penable && paddr[7:2] < TABLE_USED |-> !pslverr)
    else protocol_error("in-range APB access answered with pslverr");

  a_apb_idle: assert property (@(posedge clk_in) disable iff (rst_in)
    !psel |-> !pready && !pslverr)
    else protocol_error("APB completer responded without a transfer");

  initial begin
    logic [APB_DATA_W-1:0] new_word;
    int                    first_beat;
    rst_in    = 1'b1;
    log_frame = '0;
    log_valid = 1'b0;
    dct_ready = 1'b0;
    paddr     = '0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    pwdata    = '0;
    repeat (5) @(posedge clk_in);
    rst_in <= 1'b0;
    @(posedge clk_in);
    assert (!dct_valid && !pready && !pslverr && log_ready)
      else value_error("outputs not at their reset values after reset");

    // load and read back with the engine idle
    for (int i = 0; i < TABLE_USED; i++) begin
      write_entry(i, $random(seed), 1);
    end
    for (int i = 0; i < TABLE_USED; i++) begin
      check_entry(i, 2);
    end
    for (int i = TABLE_USED; i < TABLE_DEPTH; i++) begin
      check_bad_index(i);
    end
    for (int i = 0; i < TABLE_USED; i++) begin
      check_entry(i, 2);
    end

    repeat (3) begin
      fill_energy(1'b1, '0);
      send_frame();
    end
    fill_energy(1'b0, '0);
    send_frame();

    bp_mode = 1'b1;
    repeat (3) begin
      fill_energy(1'b1, '0);
      send_frame();
    end

    // host traffic while the frame accumulates
    fill_energy(1'b1, '0);
    new_word   = $random(seed);
    first_beat = frames_sent * N_DCT + 1;
    fork
      send_frame();
      begin
        check_entry(37, 0);
        while (beats_seen < first_beat) begin
          @(negedge clk_in);
        end
        // row 0 is finished once its beat is out
        write_entry(3, new_word, 0);
        check_entry(3, 0);
        check_entry(48, 0);
      end
    join

    // rows 0 and 1 at the cosine extremes for saturation
    bp_mode = 1'b0;
    for (int i = 0; i < 2 * NUM_FILTERS; i++) begin
      write_entry(i, (i < NUM_FILTERS) ? 32'h0000_7fff : 32'h0000_8000, 1);
    end
    fill_energy(1'b0, '1);
    send_frame();

    repeat (20) @(posedge clk_in);
    assert (exp_q.size() == 0 && !dct_valid && log_ready)
      else protocol_error("engine not idle or coefficients still missing at end of run");
    $display("checks failed: %0d", errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_in);
    $display("run did not finish within %0d cycles, stopped by the watchdog", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: mfcc_dct.f
src/mfcc_pkg.sv
src/coef_table.sv
src/coef_arbiter.sv
src/apb_coef_port.sv
src/dct_engine.sv
src/mfcc_dct_top.sv
dv/tb_mfcc_dct.sv

// File: Bender.yml
package:
  name: mfcc_dct

sources:
  - src/mfcc_pkg.sv
  - src/coef_table.sv
  - src/coef_arbiter.sv
  - src/apb_coef_port.sv
  - src/dct_engine.sv
  - src/mfcc_dct_top.sv
  - target: test
    files:
      - dv/tb_mfcc_dct.sv
